/* linkMux_cfg.svh */
`ifndef LINK_MUX_CFG_SVH
`define LINK_MUX_CFG_SVH

// number of input channels: Local, North, East, West and South.
`define LINK_PORTS 5

`define LINK_DEPTH 8   // flits per queue, kept a power of two.

`define LINK_DATA_W 32

// the length field sits in the low payload bits of a head or single flit.
`define LINK_LEN_W 12

`endif

/* flitPkg.sv */
`include "linkMux_cfg.svh"

package flitPkg;

  typedef enum logic [2:0] {
    flitIdle   = 3'd0,
    flitHead   = 3'd1,   // carries the packet length.
    flitBody   = 3'd2,
    flitTail   = 3'd3,
    flitSingle = 3'd4    // a whole packet in one flit, length included.
  } flitKind;

  // total flit count of a packet, header included.
  typedef logic [`LINK_LEN_W-1:0] flitLen;

  typedef struct packed {
    flitKind                 kind;
    logic [`LINK_DATA_W-1:0] payload;
  } flit;

endpackage

/* arbPkg.sv */
package arbPkg;

  // one-hot grant state, bit 0 is idle and bits 1 to 5 follow the port order.
  typedef enum logic [5:0] {
    gIdle  = 6'b000001,
    gLocal = 6'b000010,
    gNorth = 6'b000100,
    gEast  = 6'b001000,
    gWest  = 6'b010000,
    gSouth = 6'b100000
  } grantState;

  typedef enum logic [2:0] {
    pLocal = 3'd0,
    pNorth = 3'd1,
    pEast  = 3'd2,
    pWest  = 3'd3,
    pSouth = 3'd4
  } portId;

endpackage

/* flitChan.sv */
`timescale 1ns/10ps
`include "linkMux_cfg.svh"

interface flitChan;

  logic            req;    // at least one complete packet is queued.
  flitPkg::flit    head;
  flitPkg::flitLen len;    // only meaningful for a head or single flit.
  logic            pop;

  modport queue (
    output req,
    output head,
    output len,
    input  pop
  );

  modport arbiter (
    input  req,
    input  head,
    input  len,
    output pop
  );

endinterface

/* inputQueue.sv */
`timescale 1ns/10ps
`include "linkMux_cfg.svh"

module inputQueue (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  input  flitPkg::flit inFlit,
  output logic         inReady,
  flitChan.queue       ch
);

  localparam int DEPTH = `LINK_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  flitPkg::flit     mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   pkts;
  logic             push;
  logic             pktIn;
  logic             pktOut;

  function automatic logic isLast(flitPkg::flitKind kind);
    return (kind == flitPkg::flitTail) || (kind == flitPkg::flitSingle);
  endfunction

  assign inReady = (count != (PTR_W + 1)'(DEPTH));
  assign push    = inValid && inReady;   // a write while full is dropped.

  // a packet is complete once its last flit is stored.
  assign pktIn  = push && isLast(inFlit.kind);
  assign pktOut = ch.pop && isLast(ch.head.kind);

  assign ch.req  = (pkts != '0);
  assign ch.head = mem[rdPtr];
  assign ch.len  = ch.head.payload[`LINK_LEN_W-1:0];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      pkts  <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;   // wraps naturally since depth is a power of two.
      if (ch.pop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(ch.pop);
      pkts  <= pkts + (PTR_W + 1)'(pktIn) - (PTR_W + 1)'(pktOut);
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(inValid && !inReady))
    else $error("inputQueue: write to a full queue was dropped");

  // the arbiter pops only on a request, so an empty pop means the packet count is off.
  assert property (@(posedge clk) disable iff (rst) ch.pop |-> (count != '0))
    else $error("inputQueue: pop from an empty queue");

endmodule

/* grantTimer.sv */
`timescale 1ns/10ps

module grantTimer (
  input  logic            clk,
  input  logic            rst,
  input  flitPkg::flit    head,
  input  flitPkg::flitLen len,
  input  logic            run,
  output logic            timesUp
);

  flitPkg::flitLen limit;
  flitPkg::flitLen count;
  logic            isHeader;

  assign isHeader = (head.kind == flitPkg::flitHead) || (head.kind == flitPkg::flitSingle);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;   // one step per transferred flit.
    end
    else
    begin
      count <= '0;
      if (isHeader)
        limit <= len;   // the length stays frozen while the grant runs.
    end
  end

  // high once the whole announced packet has gone out.
  assign timesUp = (count == limit);

endmodule

/* linkArbiter.sv */
`timescale 1ns/10ps
`include "linkMux_cfg.svh"

module linkArbiter (
  input  logic          clk,
  input  logic          rst,
  flitChan.arbiter      ch[`LINK_PORTS],
  output logic          outValid,
  output flitPkg::flit  outFlit,
  output arbPkg::portId outPort
);

  localparam int PORTS = `LINK_PORTS;

  arbPkg::grantState state;
  arbPkg::grantState nextState;
  arbPkg::portId     curPort;
  logic [PORTS-1:0]  req;
  logic [PORTS-1:0]  pop;
  logic [PORTS-1:0]  timesUp;
  flitPkg::flit      head [PORTS];

  for (genvar i = 0; i < PORTS; i++)
  begin : gPort
    assign req[i]    = ch[i].req;
    assign head[i]   = ch[i].head;
    assign ch[i].pop = pop[i];

    // a port's timer runs exactly in its transfer cycles.
    grantTimer timer (
      .clk     (clk),
      .rst     (rst),
      .head    (ch[i].head),
      .len     (ch[i].len),
      .run     (pop[i]),
      .timesUp (timesUp[i])
    );
  end

  always_comb
  begin
    curPort = arbPkg::pLocal;
    for (int p = 0; p < PORTS; p++)
    begin
      if (state[p + 1])
        curPort = arbPkg::portId'(p);
    end
  end

  always_comb
  begin
    int   base;
    int   steps;
    int   idx;
    logic found;

    nextState = arbPkg::gIdle;   // nobody requesting goes back to idle.
    pop       = '0;
    found     = 1'b0;
    idx       = 0;

    if (state == arbPkg::gIdle)
    begin
      base  = PORTS - 1;   // start the scan just before Local, giving fixed priority.
      steps = PORTS;
    end
    else
    begin
      base  = int'(curPort);
      steps = PORTS - 1;   // the current port is left out of its own chain.
    end

    if (state != arbPkg::gIdle && req[curPort] && !timesUp[curPort])
    begin
      nextState    = state;
      pop[curPort] = 1'b1;
    end
    else
    begin
      for (int i = 1; i <= PORTS; i++)
      begin
        idx = (base + i) % PORTS;
        if (!found && i <= steps && req[idx])
        begin
          nextState = arbPkg::grantState'(6'b1 << (idx + 1));
          found     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbPkg::gIdle;
    else
      state <= nextState;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  // the popped head and its tag leave one cycle after the pop.
  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= head[curPort];
      outPort <= curPort;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("linkArbiter: grant state is not one-hot");

  assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("linkArbiter: more than one queue popped in a cycle");

endmodule

/* linkMux.sv */
`timescale 1ns/10ps
`include "linkMux_cfg.svh"

module linkMux (
  input  logic                             clk,
  input  logic                             rst,
  input  logic         [`LINK_PORTS-1:0]   inValid,
  input  flitPkg::flit [`LINK_PORTS-1:0]   inFlit,
  output logic         [`LINK_PORTS-1:0]   inReady,
  output logic                             outValid,
  output flitPkg::flit                     outFlit,
  output arbPkg::portId                    outPort
);

  // one channel per input port, indexed by port number.
  flitChan chan[`LINK_PORTS] ();

  for (genvar i = 0; i < `LINK_PORTS; i++)
  begin : gQueue
    inputQueue portQueue (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inFlit  (inFlit[i]),
      .inReady (inReady[i]),
      .ch      (chan[i])
    );
  end

  linkArbiter arb (
    .clk      (clk),
    .rst      (rst),
    .ch       (chan),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

/* linkMuxTb.sv */
`timescale 1ns/10ps
`include "linkMux_cfg.svh"

module linkMuxTb;

  localparam int PORTS = `LINK_PORTS;
  // every test added up, with the random test at its longest packets.
  localparam int MAX_FLITS = 4 + 5 + 5 + 4 + 3 * PORTS * 6 + 8;

  logic                       clk;
  logic                       rst;
  logic         [PORTS-1:0]   inValid;
  flitPkg::flit [PORTS-1:0]   inFlit;
  logic         [PORTS-1:0]   inReady;
  logic                       outValid;
  flitPkg::flit               outFlit;
  arbPkg::portId              outPort;

  flitPkg::flit  expQ [PORTS][$];   // flits written per port, oldest first.
  flitPkg::flit  rxFlit [$];
  arbPkg::portId rxPort [$];
  int            sent;
  int            errCount;
  int            testErrs;
  int            passCount;
  int            failCount;

  linkMux i_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  initial clk = 1'b0;

  always #4 clk = ~clk;

  // every delivered flit lands in the arrival log.
  always @(posedge clk)
  begin
    if (!rst && outValid)
    begin
      rxFlit.push_back(outFlit);
      rxPort.push_back(outPort);
    end
  end

  initial
  begin
    repeat (200 * MAX_FLITS) @(posedge clk);
    $display("error: the run did not finish within %0d cycles", 200 * MAX_FLITS);
    $display("Test failed");
    $finish;
  end

  function automatic logic [PORTS-1:0] portBit(input arbPkg::portId p);
    return PORTS'(1) << p;
  endfunction

  // flit k of a packet of len flits, the header carrying the length.
  function automatic flitPkg::flit buildFlit(input int k, input int len);
    flitPkg::flit f;
    f.payload = $urandom();
    if (len == 1)
      f.kind = flitPkg::flitSingle;
    else if (k == 0)
      f.kind = flitPkg::flitHead;
    else if (k == len - 1)
      f.kind = flitPkg::flitTail;
    else
      f.kind = flitPkg::flitBody;
    if (k == 0)
      f.payload[`LINK_LEN_W-1:0] = `LINK_LEN_W'(len);
    return f;
  endfunction

  task automatic reportError(input string name, input string msg);
    $display("error in %s: %s", name, msg);
    errCount++;
  endtask

  task automatic checkFlit(input string name, input flitPkg::flit exp, input flitPkg::flit act);
    if (act !== exp)
    begin
      $display("mismatch in %s: expected kind %0d payload %h, actual kind %0d payload %h",
               name, exp.kind, exp.payload, act.kind, act.payload);
      errCount++;
    end
  endtask

  task automatic checkPort(input string name, input arbPkg::portId exp,
                           input arbPkg::portId act);
    if (act !== exp)
    begin
      $display("mismatch in %s: expected port %0d, actual port %0d", name, exp, act);
      errCount++;
    end
  endtask

  task automatic checkLevel(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("mismatch in %s: expected inReady %b, actual inReady %b", name, exp, act);
      errCount++;
    end
  endtask

  task automatic startTest();
    rxFlit.delete();
    rxPort.delete();
    for (int p = 0; p < PORTS; p++)
      expQ[p].delete();
    sent     = 0;
    testErrs = errCount;
  endtask

  task automatic finishTest(input string name);
    if (errCount == testErrs)
    begin
      $display("%s: ok", name);
      passCount++;
    end
    else
    begin
      $display("%s: %0d errors", name, errCount - testErrs);
      failCount++;
    end
  endtask

  task automatic driveCycle(input logic [PORTS-1:0] valid, input flitPkg::flit [PORTS-1:0] flits);
    @(posedge clk);
    inValid <= valid;
    inFlit  <= flits;
    for (int p = 0; p < PORTS; p++)
    begin
      if (valid[p])
      begin
        expQ[p].push_back(flits[p]);
        sent++;
      end
    end
  endtask

  task automatic releaseInputs();
    @(posedge clk);
    inValid <= '0;
  endtask

  task automatic waitDrain(input string name);
    int waited;
    waited = 0;
    while (rxFlit.size() < sent && waited < 200 * sent)
    begin
      @(posedge clk);
      waited++;
    end
    repeat (8) @(posedge clk);   // a quiet spell shows up any extra flit.
    if (rxFlit.size() != sent)
      reportError(name, $sformatf("%0d flits sent but %0d delivered", sent, rxFlit.size()));
  endtask

  // per port the arrivals must match the writes in order and content.
  task automatic checkArrivals(input string name);
    int p;
    for (int i = 0; i < rxFlit.size(); i++)
    begin
      p = int'(rxPort[i]);
      if (p >= PORTS)
        reportError(name, $sformatf("flit %0d carries an unknown port tag %0d", i, p));
      else if (expQ[p].size() == 0)
        reportError(name, $sformatf("port %0d delivered more flits than were written", p));
      else
        checkFlit(name, expQ[p].pop_front(), rxFlit[i]);
    end
  endtask

  task automatic checkOrder(input string name, input arbPkg::portId order[$]);
    for (int i = 0; i < order.size() && i < rxPort.size(); i++)
      checkPort(name, order[i], rxPort[i]);
  endtask

  task automatic checkPackets(input string name);
    int               remain;
    arbPkg::portId    cur;
    flitPkg::flitKind kind;
    remain = 0;
    cur    = arbPkg::pLocal;
    for (int i = 0; i < rxFlit.size(); i++)
    begin
      kind = rxFlit[i].kind;
      if (remain <= 0)
      begin
        if (kind != flitPkg::flitHead && kind != flitPkg::flitSingle)
          reportError(name, $sformatf("flit %0d opens a packet without a header", i));
        remain = int'(rxFlit[i].payload[`LINK_LEN_W-1:0]);
        cur    = rxPort[i];
      end
      else
        checkPort(name, cur, rxPort[i]);   // another port cut into the packet.
      remain--;
      if (remain == 0 && kind != flitPkg::flitTail && kind != flitPkg::flitSingle)
        reportError(name, $sformatf("flit %0d closes a packet but is no tail", i));
    end
    if (remain > 0)
      reportError(name, $sformatf("the last packet is short by %0d flits", remain));
  endtask

  task automatic testSinglePort();
    flitPkg::flit [PORTS-1:0] v;
    arbPkg::portId            order[$];
    startTest();
    v = '0;
    for (int k = 0; k < 4; k++)
    begin
      v[arbPkg::pNorth] = buildFlit(k, 4);
      driveCycle(portBit(arbPkg::pNorth), v);
      order.push_back(arbPkg::pNorth);
    end
    releaseInputs();
    waitDrain("single port packet");
    checkArrivals("single port packet");
    checkOrder("single port packet", order);
    finishTest("single port packet");
  endtask

  task automatic testSingleFlits();
    flitPkg::flit [PORTS-1:0] v;
    arbPkg::portId            order[$];
    startTest();
    for (int p = 0; p < PORTS; p++)
    begin
      v    = '0;
      v[p] = buildFlit(0, 1);
      driveCycle(portBit(arbPkg::portId'(p)), v);
      releaseInputs();
      waitDrain("one flit packets");
      order.push_back(arbPkg::portId'(p));
    end
    checkArrivals("one flit packets");
    checkOrder("one flit packets", order);
    finishTest("one flit packets");
  endtask

  task automatic testPriority();
    flitPkg::flit [PORTS-1:0] v;
    arbPkg::portId            order[$];
    startTest();
    for (int p = 0; p < PORTS; p++)
    begin
      v[p] = buildFlit(0, 1);
      order.push_back(arbPkg::portId'(p));   // fixed priority from idle is port order.
    end
    driveCycle('1, v);
    releaseInputs();
    waitDrain("priority from idle");
    checkArrivals("priority from idle");
    checkOrder("priority from idle", order);
    finishTest("priority from idle");
  endtask

  task automatic testRotation();
    flitPkg::flit [PORTS-1:0] v;
    arbPkg::portId            order[$];
    startTest();
    v = '0;
    for (int n = 0; n < 2; n++)
    begin
      v[arbPkg::pLocal] = buildFlit(0, 1);
      v[arbPkg::pSouth] = buildFlit(0, 1);
      driveCycle(portBit(arbPkg::pLocal) | portBit(arbPkg::pSouth), v);
      order.push_back(arbPkg::pLocal);
      order.push_back(arbPkg::pSouth);
    end
    releaseInputs();
    waitDrain("rotation");
    checkArrivals("rotation");
    checkOrder("rotation", order);
    finishTest("rotation");
  endtask

  task automatic testIntegrity();
    flitPkg::flit [PORTS-1:0] v;
    logic         [PORTS-1:0] valid;
    int                       lens [PORTS];
    startTest();
    for (int r = 0; r < 3; r++)
    begin
      for (int p = 0; p < PORTS; p++)
        lens[p] = 1 + ($urandom() % 6);
      for (int c = 0; c < 6; c++)
      begin
        v     = '0;
        valid = '0;
        for (int p = 0; p < PORTS; p++)
        begin
          if (c < lens[p])
          begin
            v[p]     = buildFlit(c, lens[p]);
            valid[p] = 1'b1;
          end
        end
        driveCycle(valid, v);
      end
      releaseInputs();
      waitDrain("packet integrity");   // one round at a time keeps every queue below full.
    end
    checkArrivals("packet integrity");
    checkPackets("packet integrity");
    finishTest("packet integrity");
  endtask

  task automatic testFullQueue();
    flitPkg::flit [PORTS-1:0] v;
    startTest();
    v = '0;
    for (int k = 0; k < 7; k++)
    begin
      v[arbPkg::pEast] = buildFlit(k, 8);
      driveCycle(portBit(arbPkg::pEast), v);
    end
    releaseInputs();
    repeat (5) @(posedge clk);
    if (rxFlit.size() != 0)
      reportError("full queue", "flits left before their packet was complete");
    @(negedge clk);
    checkLevel("full queue", 1'b1, inReady[arbPkg::pEast]);
    v[arbPkg::pEast] = buildFlit(7, 8);
    driveCycle(portBit(arbPkg::pEast), v);
    releaseInputs();
    @(negedge clk);
    checkLevel("full queue", 1'b0, inReady[arbPkg::pEast]);   // eight flits held, no room.
    waitDrain("full queue");
    @(negedge clk);
    checkLevel("full queue", 1'b1, inReady[arbPkg::pEast]);
    checkArrivals("full queue");
    checkPackets("full queue");
    finishTest("full queue");
  endtask

  initial
  begin
    void'($urandom(69));
    rst       = 1'b1;
    inValid   = '0;
    inFlit    = '0;
    errCount  = 0;
    passCount = 0;
    failCount = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    testSinglePort();
    testSingleFlits();
    testPriority();
    testRotation();
    testIntegrity();
    testFullQueue();
    $display("tests: %0d ok, %0d with errors", passCount, failCount);
    if (failCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
flitPkg.sv
arbPkg.sv
flitChan.sv
inputQueue.sv
grantTimer.sv
linkArbiter.sv
linkMux.sv
linkMuxTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and judges the result from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module linkMuxTb -f files.f \
  -o linkMuxSim \
  && ./obj_dir/linkMuxSim > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Test completed successfully$" sim.log && exit 0 || exit 1
